/* icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int ADDR_WIDTH     = 32;
    localparam int WORD_WIDTH     = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int SET_NUM        = 16;
    localparam int WAY_NUM        = 2;
    localparam int TXNID_WIDTH    = 4;
    localparam int MSHR_ENTRY_NUM = 2;

    // the byte offset inside a word sits below the word select
    localparam int OFFSET_WIDTH = $clog2(WORDS_PER_LINE);
    localparam int INDEX_WIDTH  = $clog2(SET_NUM);
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - $clog2(WORD_WIDTH / 8);

    typedef logic [ADDR_WIDTH-1:0]                addr_t;
    typedef logic [WORD_WIDTH-1:0]                word_t;
    typedef logic [WORDS_PER_LINE*WORD_WIDTH-1:0] line_t;
    typedef logic [TAG_WIDTH-1:0]                 tag_t;
    typedef logic [INDEX_WIDTH-1:0]               index_t;
    typedef logic [OFFSET_WIDTH-1:0]              offset_t;
    typedef logic [TXNID_WIDTH-1:0]               txnid_t;
    typedef logic [$clog2(WAY_NUM)-1:0]           way_t;
    typedef logic [$clog2(MSHR_ENTRY_NUM)-1:0]    entry_idx_t;

    // kind of request held in the lookup stage
    typedef enum logic {
        REQ_FETCH,
        REQ_SNOOP
    } req_kind_t;

    function automatic tag_t get_tag(addr_t a);
        return a[ADDR_WIDTH-1 -: TAG_WIDTH];
    endfunction

    function automatic index_t get_index(addr_t a);
        return a[ADDR_WIDTH-TAG_WIDTH-1 -: INDEX_WIDTH];
    endfunction

    function automatic offset_t get_offset(addr_t a);
        return a[ADDR_WIDTH-TAG_WIDTH-INDEX_WIDTH-1 -: OFFSET_WIDTH];
    endfunction

    // byte address of the first word of the line
    function automatic addr_t line_addr(addr_t a);
        return {get_tag(a), get_index(a), {(ADDR_WIDTH-TAG_WIDTH-INDEX_WIDTH){1'b0}}};
    endfunction

endpackage

`default_nettype wire

/* icache_miss_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface icache_miss_if
    import icache_pkg::*;
    ();

    logic   vld;
    logic   rdy;
    addr_t  addr;
    txnid_t txnid;
    way_t   way;

    // tag control side
    modport master (
        output vld, addr, txnid, way,
        input  rdy
    );

    // miss file side
    modport target (
        input  vld, addr, txnid, way,
        output rdy
    );

endinterface

`default_nettype wire

/* icache_fill_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface icache_fill_if
    import icache_pkg::*;
    ();

    logic       vld;
    entry_idx_t idx;
    addr_t      addr;
    way_t       way;
    txnid_t     txnid;

    // data control raises the pulse and names the entry
    modport master (
        output vld, idx,
        input  addr, way, txnid
    );

    // miss file looks the entry up and frees it
    modport target (
        input  vld, idx,
        output addr, way, txnid
    );

    modport monitor (
        input vld, addr, way
    );

endinterface

`default_nettype wire

/* icache_req_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_req_arbiter
    import icache_pkg::*;
    (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      mshr_idle,
    input  logic      fetch_vld,
    output logic      fetch_rdy,
    input  addr_t     fetch_addr,
    input  txnid_t    fetch_txnid,
    input  logic      snp_vld,
    output logic      snp_rdy,
    input  addr_t     snp_addr,
    output logic      lookup_vld,
    input  logic      lookup_rdy,
    output req_kind_t lookup_kind,
    output addr_t     lookup_addr,
    output txnid_t    lookup_txnid
    );

    logic snp_sel;

    // snoop wins, but only while no miss is in flight
    assign snp_sel      = snp_vld && mshr_idle;
    assign lookup_vld   = snp_sel || fetch_vld;
    assign lookup_kind  = snp_sel ? REQ_SNOOP : REQ_FETCH;
    assign lookup_addr  = snp_sel ? snp_addr : fetch_addr;
    assign lookup_txnid = fetch_txnid;

    assign snp_rdy   = lookup_rdy && mshr_idle;
    assign fetch_rdy = lookup_rdy && !snp_sel;

    // a fetch that loses the grant keeps its request steady
    a_fetch_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch_vld && !fetch_rdy |=> fetch_vld && $stable(fetch_addr) && $stable(fetch_txnid)
    ) else $error("fetch request dropped or changed while waiting for the grant");

endmodule

`default_nettype wire

/* icache_tag_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tag_ctrl
    import icache_pkg::*;
    (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                lookup_vld,
    output logic                lookup_rdy,
    input  req_kind_t           lookup_kind,
    input  addr_t               lookup_addr,
    input  txnid_t              lookup_txnid,
    icache_miss_if.master       miss,
    icache_fill_if.monitor      fill,
    output logic                hit_vld,
    input  logic                hit_rdy,
    output index_t              hit_index,
    output way_t                hit_way,
    output offset_t             hit_offset,
    output txnid_t              hit_txnid
    );

    logic               req_vld;
    req_kind_t          req_kind;
    addr_t              req_addr;
    txnid_t             req_txnid;

    tag_t               tag_arr   [SET_NUM][WAY_NUM];
    logic [WAY_NUM-1:0] valid_q   [SET_NUM];
    way_t               victim_q  [SET_NUM];
    // one outstanding miss per set keeps two fills off the same way
    logic [SET_NUM-1:0] pend_q;

    index_t             req_index;
    index_t             fill_index;
    logic [WAY_NUM-1:0] hit_vec;
    logic               is_fetch;
    logic               is_snoop;
    logic               hit;
    way_t               vict_way;
    logic               miss_fire;
    logic               drain;

    assign req_index  = get_index(req_addr);
    assign fill_index = get_index(fill.addr);
    assign is_fetch   = req_vld && (req_kind == REQ_FETCH);
    assign is_snoop   = req_vld && (req_kind == REQ_SNOOP);

    always_comb begin
        hit_way  = '0;
        vict_way = victim_q[req_index];
        for (int w = 0; w < WAY_NUM; w++) begin
            hit_vec[w] = valid_q[req_index][w] && (tag_arr[req_index][w] == get_tag(req_addr));
            if (hit_vec[w]) begin
                hit_way = way_t'(w);
            end
        end
        // invalid way first, lowest one wins
        for (int w = WAY_NUM - 1; w >= 0; w--) begin
            if (!valid_q[req_index][w]) begin
                vict_way = way_t'(w);
            end
        end
    end

    assign hit        = |hit_vec;
    assign hit_vld    = is_fetch && hit;
    assign hit_index  = req_index;
    assign hit_offset = get_offset(req_addr);
    assign hit_txnid  = req_txnid;

    assign miss.vld   = is_fetch && !hit && !pend_q[req_index];
    assign miss.addr  = req_addr;
    assign miss.txnid = req_txnid;
    assign miss.way   = vict_way;
    assign miss_fire  = miss.vld && miss.rdy;

    // a waiting miss stays put and looks up again next cycle
    assign drain      = is_snoop || (hit_vld && hit_rdy) || miss_fire;
    assign lookup_rdy = !req_vld || drain;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_vld <= 1'b0;
        end else if (lookup_vld && lookup_rdy) begin
            req_vld <= 1'b1;
        end else if (drain) begin
            req_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_vld && lookup_rdy) begin
            req_kind  <= lookup_kind;
            req_addr  <= lookup_addr;
            req_txnid <= lookup_txnid;
        end
        if (fill.vld) begin
            tag_arr[fill_index][fill.way] <= get_tag(fill.addr);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= '0;
            for (int s = 0; s < SET_NUM; s++) begin
                valid_q[s]  <= '0;
                victim_q[s] <= '0;
            end
        end else begin
            if (is_snoop) begin
                valid_q[req_index] <= valid_q[req_index] & ~hit_vec;
            end
            if (miss_fire) begin
                valid_q[req_index][vict_way] <= 1'b0;
                victim_q[req_index]          <= victim_q[req_index] + 1'b1;
                pend_q[req_index]            <= 1'b1;
            end
            if (fill.vld) begin
                valid_q[fill_index][fill.way] <= 1'b1;
                pend_q[fill_index]            <= 1'b0;
            end
        end
    end

    a_hit_onehot : assert property (
        @(posedge clk) disable iff (!rst_n)
        req_vld |-> $onehot0(hit_vec)
    ) else $error("more than one way hit");

endmodule

`default_nettype wire

/* icache_mshr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_mshr_file
    import icache_pkg::*;
    (
    input  logic                clk,
    input  logic                rst_n,
    icache_miss_if.target       miss,
    icache_fill_if.target       fill,
    output logic                mshr_idle,
    output logic                downstream_txreq_vld,
    input  logic                downstream_txreq_rdy,
    output addr_t               downstream_txreq_addr,
    output entry_idx_t          downstream_txreq_entry_id
    );

    logic [MSHR_ENTRY_NUM-1:0] busy_q;
    addr_t                     e_addr  [MSHR_ENTRY_NUM];
    way_t                      e_way   [MSHR_ENTRY_NUM];
    txnid_t                    e_txnid [MSHR_ENTRY_NUM];

    logic [MSHR_ENTRY_NUM-1:0] same_line;
    entry_idx_t                free_idx;
    logic                      txreq_free;
    logic                      alloc;

    always_comb begin
        free_idx = '0;
        for (int i = MSHR_ENTRY_NUM - 1; i >= 0; i--) begin
            same_line[i] = busy_q[i] && (line_addr(e_addr[i]) == line_addr(miss.addr));
            if (!busy_q[i]) begin
                free_idx = entry_idx_t'(i);
            end
        end
    end

    // request register must have room, else the line request is lost
    assign txreq_free = !downstream_txreq_vld || downstream_txreq_rdy;
    assign miss.rdy   = !(&busy_q) && !(|same_line) && txreq_free;
    assign alloc      = miss.vld && miss.rdy;
    assign mshr_idle  = !(|busy_q) && !miss.vld;

    assign fill.addr  = e_addr[fill.idx];
    assign fill.way   = e_way[fill.idx];
    assign fill.txnid = e_txnid[fill.idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q               <= '0;
            downstream_txreq_vld <= 1'b0;
        end else begin
            if (alloc) begin
                busy_q[free_idx] <= 1'b1;
            end
            if (fill.vld) begin
                busy_q[fill.idx] <= 1'b0;
            end
            if (txreq_free) begin
                downstream_txreq_vld <= alloc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            e_addr[free_idx]          <= miss.addr;
            e_way[free_idx]           <= miss.way;
            e_txnid[free_idx]         <= miss.txnid;
            downstream_txreq_addr     <= line_addr(miss.addr);
            downstream_txreq_entry_id <= free_idx;
        end
    end

    a_fill_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        fill.vld |-> busy_q[fill.idx]
    ) else $error("line fill names a free miss entry");

endmodule

`default_nettype wire

/* icache_data_array_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_data_array_ctrl
    import icache_pkg::*;
    (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hit_vld,
    output logic                hit_rdy,
    input  index_t              hit_index,
    input  way_t                hit_way,
    input  offset_t             hit_offset,
    input  txnid_t              hit_txnid,
    icache_fill_if.master       fill,
    input  logic                downstream_rxdat_vld,
    output logic                downstream_rxdat_rdy,
    input  line_t               downstream_rxdat_data,
    input  entry_idx_t          downstream_rxdat_entry_id,
    output logic                upstream_txdat_vld,
    input  logic                upstream_txdat_rdy,
    output word_t               upstream_txdat_data,
    output txnid_t              upstream_txdat_txnid
    );

    line_t  data_arr [SET_NUM][WAY_NUM];

    // read stage between the hit handshake and the output register
    logic   rd_vld;
    word_t  rd_word;
    txnid_t rd_txnid;

    logic   out_free;
    logic   hit_fire;
    logic   rd_retire;
    line_t  hit_line;

    assign out_free             = !upstream_txdat_vld || upstream_txdat_rdy;
    assign downstream_rxdat_rdy = out_free;

    assign fill.vld = downstream_rxdat_vld && downstream_rxdat_rdy;
    assign fill.idx = downstream_rxdat_entry_id;

    // fill owns the output register and the array in its cycle
    assign rd_retire = rd_vld && out_free && !downstream_rxdat_vld;
    assign hit_rdy   = !downstream_rxdat_vld && (!rd_vld || out_free);
    assign hit_fire  = hit_vld && hit_rdy;
    assign hit_line  = data_arr[hit_index][hit_way];

    always_ff @(posedge clk) begin
        if (fill.vld) begin
            data_arr[get_index(fill.addr)][fill.way] <= downstream_rxdat_data;
        end
        if (hit_fire) begin
            rd_word  <= hit_line[hit_offset*WORD_WIDTH +: WORD_WIDTH];
            rd_txnid <= hit_txnid;
        end
        if (fill.vld) begin
            upstream_txdat_data  <=
                downstream_rxdat_data[get_offset(fill.addr)*WORD_WIDTH +: WORD_WIDTH];
            upstream_txdat_txnid <= fill.txnid;
        end else if (rd_retire) begin
            upstream_txdat_data  <= rd_word;
            upstream_txdat_txnid <= rd_txnid;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld             <= 1'b0;
            upstream_txdat_vld <= 1'b0;
        end else begin
            rd_vld <= hit_fire || (rd_vld && !rd_retire);
            if (out_free) begin
                upstream_txdat_vld <= fill.vld || rd_retire;
            end
        end
    end

endmodule

`default_nettype wire

/* icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top
    import icache_pkg::*;
    (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        upstream_rxreq_vld,
    output logic        upstream_rxreq_rdy,
    input  addr_t       upstream_rxreq_addr,
    input  txnid_t      upstream_rxreq_txnid,
    input  logic        downstream_rxsnp_vld,
    output logic        downstream_rxsnp_rdy,
    input  addr_t       downstream_rxsnp_addr,
    output logic        downstream_txreq_vld,
    input  logic        downstream_txreq_rdy,
    output addr_t       downstream_txreq_addr,
    output entry_idx_t  downstream_txreq_entry_id,
    input  logic        downstream_rxdat_vld,
    output logic        downstream_rxdat_rdy,
    input  line_t       downstream_rxdat_data,
    input  entry_idx_t  downstream_rxdat_entry_id,
    output logic        upstream_txdat_vld,
    input  logic        upstream_txdat_rdy,
    output word_t       upstream_txdat_data,
    output txnid_t      upstream_txdat_txnid
    );

    logic       mshr_idle;
    logic       lookup_vld;
    logic       lookup_rdy;
    req_kind_t  lookup_kind;
    addr_t      lookup_addr;
    txnid_t     lookup_txnid;
    logic       hit_vld;
    logic       hit_rdy;
    index_t     hit_index;
    way_t       hit_way;
    offset_t    hit_offset;
    txnid_t     hit_txnid;

    icache_miss_if miss_if ();
    icache_fill_if fill_if ();

    icache_req_arbiter u_icache_req_arbiter (
        .clk          (clk                  ),
        .rst_n        (rst_n                ),
        .mshr_idle    (mshr_idle            ),
        .fetch_vld    (upstream_rxreq_vld   ),
        .fetch_rdy    (upstream_rxreq_rdy   ),
        .fetch_addr   (upstream_rxreq_addr  ),
        .fetch_txnid  (upstream_rxreq_txnid ),
        .snp_vld      (downstream_rxsnp_vld ),
        .snp_rdy      (downstream_rxsnp_rdy ),
        .snp_addr     (downstream_rxsnp_addr),
        .lookup_vld   (lookup_vld           ),
        .lookup_rdy   (lookup_rdy           ),
        .lookup_kind  (lookup_kind          ),
        .lookup_addr  (lookup_addr          ),
        .lookup_txnid (lookup_txnid         )
    );

    icache_tag_ctrl u_icache_tag_ctrl (
        .clk          (clk          ),
        .rst_n        (rst_n        ),
        .lookup_vld   (lookup_vld   ),
        .lookup_rdy   (lookup_rdy   ),
        .lookup_kind  (lookup_kind  ),
        .lookup_addr  (lookup_addr  ),
        .lookup_txnid (lookup_txnid ),
        .miss         (miss_if      ),
        .fill         (fill_if      ),
        .hit_vld      (hit_vld      ),
        .hit_rdy      (hit_rdy      ),
        .hit_index    (hit_index    ),
        .hit_way      (hit_way      ),
        .hit_offset   (hit_offset   ),
        .hit_txnid    (hit_txnid    )
    );

    icache_mshr_file u_icache_mshr_file (
        .clk                       (clk                      ),
        .rst_n                     (rst_n                    ),
        .miss                      (miss_if                  ),
        .fill                      (fill_if                  ),
        .mshr_idle                 (mshr_idle                ),
        .downstream_txreq_vld      (downstream_txreq_vld     ),
        .downstream_txreq_rdy      (downstream_txreq_rdy     ),
        .downstream_txreq_addr     (downstream_txreq_addr    ),
        .downstream_txreq_entry_id (downstream_txreq_entry_id)
    );

    icache_data_array_ctrl u_icache_data_array_ctrl (
        .clk                       (clk                      ),
        .rst_n                     (rst_n                    ),
        .hit_vld                   (hit_vld                  ),
        .hit_rdy                   (hit_rdy                  ),
        .hit_index                 (hit_index                ),
        .hit_way                   (hit_way                  ),
        .hit_offset                (hit_offset               ),
        .hit_txnid                 (hit_txnid                ),
        .fill                      (fill_if                  ),
        .downstream_rxdat_vld      (downstream_rxdat_vld     ),
        .downstream_rxdat_rdy      (downstream_rxdat_rdy     ),
        .downstream_rxdat_data     (downstream_rxdat_data    ),
        .downstream_rxdat_entry_id (downstream_rxdat_entry_id),
        .upstream_txdat_vld        (upstream_txdat_vld       ),
        .upstream_txdat_rdy        (upstream_txdat_rdy       ),
        .upstream_txdat_data       (upstream_txdat_data      ),
        .upstream_txdat_txnid      (upstream_txdat_txnid     )
    );

endmodule

`default_nettype wire

/* tb_icache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_icache
    import icache_pkg::*;
    ();

    localparam int DIRECT_FETCHES = 12;
    localparam int RAND_FETCHES   = 40;
    localparam int CYCLE_LIMIT    = (DIRECT_FETCHES + RAND_FETCHES) * 60 + 200;
    localparam int REQ_MAX        = 64;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       upstream_rxreq_vld;
    logic       upstream_rxreq_rdy;
    addr_t      upstream_rxreq_addr;
    txnid_t     upstream_rxreq_txnid;
    logic       downstream_rxsnp_vld;
    logic       downstream_rxsnp_rdy;
    addr_t      downstream_rxsnp_addr;
    logic       downstream_txreq_vld;
    logic       downstream_txreq_rdy;
    addr_t      downstream_txreq_addr;
    entry_idx_t downstream_txreq_entry_id;
    logic       downstream_rxdat_vld;
    logic       downstream_rxdat_rdy;
    line_t      downstream_rxdat_data;
    entry_idx_t downstream_rxdat_entry_id;
    logic       upstream_txdat_vld;
    logic       upstream_txdat_rdy;
    word_t      upstream_txdat_data;
    txnid_t     upstream_txdat_txnid;

    // main process state
    int          issued [16];
    addr_t       exp_addr [16];
    addr_t       pred_addr [REQ_MAX];
    int          pred_cnt = 0;
    logic [23:0] m_tag [16][2];
    bit          m_vld [16][2];
    bit          m_rr [16];
    txnid_t      next_txnid = '0;
    int          main_errs = 0;
    bit          mem_hold = 1'b0;
    bit          mem_lifo = 1'b0;
    bit          stall_en = 1'b0;
    int          seed = 32'h5d15;

    // monitor state
    int          cycle_cnt = 0;
    int          req_cnt = 0;
    addr_t       req_log_addr [REQ_MAX];
    entry_idx_t  req_log_id [REQ_MAX];
    int          rxdat_xfer_cnt = 0;
    int          returned [16];
    int          mon_errs = 0;
    bit          held_vld = 1'b0;
    word_t       held_data;
    txnid_t      held_txnid;

    // memory model state
    int          due [REQ_MAX];
    bit          served [REQ_MAX];
    int          seen_cnt = 0;
    int          dat_sent = 0;
    int          mem_seed = 32'h5d15;

    icache_top i_icache_top (.*);

    always #10 clk = ~clk;

    // line address times 7 plus word offset
    function automatic word_t expected_word(input addr_t a);
        addr_t line;
        line = {a[31:4], 4'b0000};
        return line * 32'd7 + {30'd0, a[3:2]};
    endfunction

    function automatic line_t build_line(input addr_t line);
        line_t d;
        for (int w = 0; w < 4; w++) begin
            d[w*32 +: 32] = expected_word(line + addr_t'(w * 4));
        end
        return d;
    endfunction

    // tag model picks an invalid way first and then the round-robin way
    task automatic model_fetch(input addr_t a);
        int          s;
        int          v;
        logic [23:0] tg;
        bit          hit;
        s   = int'(a[7:4]);
        tg  = a[31:8];
        hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_vld[s][w] && m_tag[s][w] == tg) begin
                hit = 1'b1;
            end
        end
        if (!hit) begin
            if (!m_vld[s][0]) begin
                v = 0;
            end else if (!m_vld[s][1]) begin
                v = 1;
            end else begin
                v = int'(m_rr[s]);
            end
            m_vld[s][v] = 1'b1;
            m_tag[s][v] = tg;
            m_rr[s]     = !m_rr[s];
            pred_addr[pred_cnt] = {a[31:4], 4'b0000};
            pred_cnt++;
        end
    endtask

    task automatic model_snoop(input addr_t a);
        int s;
        s = int'(a[7:4]);
        for (int w = 0; w < 2; w++) begin
            if (m_vld[s][w] && m_tag[s][w] == a[31:8]) begin
                m_vld[s][w] = 1'b0;
            end
        end
    endtask

    // called right after a falling edge
    task automatic send_fetch(input addr_t a);
        txnid_t t;
        t = next_txnid;
        while (returned[t] != issued[t]) begin
            @(negedge clk);
        end
        next_txnid = next_txnid + 1'b1;
        model_fetch(a);
        exp_addr[t] = a;
        issued[t]++;
        upstream_rxreq_vld   = 1'b1;
        upstream_rxreq_addr  = a;
        upstream_rxreq_txnid = t;
        @(posedge clk);
        while (!upstream_rxreq_rdy) begin
            @(posedge clk);
        end
        @(negedge clk);
        upstream_rxreq_vld = 1'b0;
    endtask

    task automatic send_snoop(input addr_t a);
        model_snoop(a);
        downstream_rxsnp_vld  = 1'b1;
        downstream_rxsnp_addr = a;
        @(posedge clk);
        while (!downstream_rxsnp_rdy) begin
            @(posedge clk);
        end
        @(negedge clk);
        downstream_rxsnp_vld = 1'b0;
    endtask

    task automatic check_requests();
        assert (req_cnt == pred_cnt) else begin
            $display("Fail %0t: %0d line requests seen, %0d predicted",
                     $time, req_cnt, pred_cnt);
            main_errs++;
        end
    endtask

    task automatic wait_requests();
        while (req_cnt < pred_cnt) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_idle();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = 1'b0;
            for (int t = 0; t < 16; t++) begin
                if (returned[t] != issued[t]) begin
                    busy = 1'b1;
                end
            end
        end
        check_requests();
    endtask

    initial begin
        int    r;
        addr_t a;
        rst_n                 = 1'b0;
        upstream_rxreq_vld    = 1'b0;
        upstream_rxreq_addr   = '0;
        upstream_rxreq_txnid  = '0;
        downstream_rxsnp_vld  = 1'b0;
        downstream_rxsnp_addr = '0;
        for (int t = 0; t < 16; t++) begin
            issued[t] = 0;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // cold miss, hit, then eviction in set 1
        send_fetch(32'h0000_1014);
        wait_idle();
        send_fetch(32'h0000_101c);
        send_fetch(32'h0000_2010);
        send_fetch(32'h0000_3018);
        send_fetch(32'h0000_1010);
        send_fetch(32'h0000_3014);
        wait_idle();

        // two misses answered in reverse order
        mem_hold = 1'b1;
        send_fetch(32'h0000_4020);
        send_fetch(32'h0000_5034);
        wait_requests();
        // both requests are due before the memory answers
        repeat (10) @(negedge clk);
        mem_lifo = 1'b1;
        mem_hold = 1'b0;
        wait_idle();
        mem_lifo = 1'b0;

        // same line while its miss is pending
        mem_hold = 1'b1;
        send_fetch(32'h0000_6040);
        send_fetch(32'h0000_604c);
        wait_requests();
        repeat (10) @(negedge clk);
        mem_hold = 1'b0;
        wait_idle();

        // snoop drops a resident line
        send_snoop(32'h0000_1010);
        send_fetch(32'h0000_1018);
        send_fetch(32'h0000_3010);
        wait_idle();

        // random traffic under stalls over 4 sets and 4 tags
        stall_en = 1'b1;
        for (int i = 0; i < RAND_FETCHES; i++) begin
            r = $random(seed);
            a = {22'd0, r[9:8], 2'b00, r[5:4], r[1:0], 2'b00};
            send_fetch(a);
        end
        wait_idle();
        stall_en = 1'b0;

        $display("errors: monitor %0d, final %0d", mon_errs, main_errs);
        if (mon_errs + main_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    always @(posedge clk) begin : monitor
        txnid_t t;
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end else if (rst_n) begin
            if (downstream_txreq_vld && downstream_txreq_rdy) begin
                assert (req_cnt < pred_cnt && downstream_txreq_addr == pred_addr[req_cnt])
                else begin
                    $display("Fail %0t: unexpected line request for %h",
                             $time, downstream_txreq_addr);
                    mon_errs++;
                end
                req_log_addr[req_cnt] = downstream_txreq_addr;
                req_log_id[req_cnt]   = downstream_txreq_entry_id;
                req_cnt++;
            end
            if (downstream_rxdat_vld && downstream_rxdat_rdy) begin
                rxdat_xfer_cnt++;
            end
            // held word must not move while the consumer stalls
            if (held_vld) begin
                assert (upstream_txdat_vld && upstream_txdat_data == held_data &&
                        upstream_txdat_txnid == held_txnid) else begin
                    $display("Fail %0t: held return changed while not ready", $time);
                    mon_errs++;
                end
            end
            held_vld   = upstream_txdat_vld && !upstream_txdat_rdy;
            held_data  = upstream_txdat_data;
            held_txnid = upstream_txdat_txnid;
            if (upstream_txdat_vld && upstream_txdat_rdy) begin
                t = upstream_txdat_txnid;
                assert (issued[t] == returned[t] + 1) else begin
                    $display("Fail %0t: return with txnid %0d not outstanding", $time, t);
                    mon_errs++;
                end
                assert (upstream_txdat_data == expected_word(exp_addr[t])) else begin
                    $display("Fail %0t: txnid %0d returned %h, expected %h", $time, t,
                             upstream_txdat_data, expected_word(exp_addr[t]));
                    mon_errs++;
                end
                returned[t]++;
            end
        end
    end

    // memory model answering line requests after a random delay
    initial begin
        int pick;
        for (int t = 0; t < 16; t++) begin
            returned[t] = 0;
        end
        downstream_rxdat_vld      = 1'b0;
        downstream_rxdat_data     = '0;
        downstream_rxdat_entry_id = '0;
        downstream_txreq_rdy      = 1'b1;
        upstream_txdat_rdy        = 1'b1;
        forever begin
            @(negedge clk);
            if (downstream_rxdat_vld && rxdat_xfer_cnt != dat_sent) begin
                dat_sent++;
                downstream_rxdat_vld = 1'b0;
            end
            while (seen_cnt < req_cnt) begin
                due[seen_cnt]    = cycle_cnt + 2 + ($random(mem_seed) & 7);
                served[seen_cnt] = 1'b0;
                seen_cnt++;
            end
            if (!downstream_rxdat_vld && !mem_hold) begin
                pick = -1;
                // oldest due request, or newest when reversing
                for (int i = 0; i < seen_cnt; i++) begin
                    if (!served[i] && due[i] <= cycle_cnt && (pick < 0 || mem_lifo)) begin
                        pick = i;
                    end
                end
                if (pick >= 0) begin
                    served[pick]              = 1'b1;
                    downstream_rxdat_vld      = 1'b1;
                    downstream_rxdat_entry_id = req_log_id[pick];
                    downstream_rxdat_data     = build_line(req_log_addr[pick]);
                end
            end
            upstream_txdat_rdy   = stall_en ? (($random(mem_seed) & 3) != 0) : 1'b1;
            downstream_txreq_rdy = stall_en ? (($random(mem_seed) & 1) != 0) : 1'b1;
        end
    end

endmodule

`default_nettype wire

/* icache.f */
icache_pkg.sv
icache_miss_if.sv
icache_fill_if.sv
icache_req_arbiter.sv
icache_tag_ctrl.sv
icache_mshr_file.sv
icache_data_array_ctrl.sv
icache_top.sv
tb_icache.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_icache -f icache.f -o sim_icache

./obj_dir/sim_icache > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
grep -q "=== PASS ===" sim.log
